/* include/lsu_unused.svh */
`ifndef LSU_UNUSED_SVH
`define LSU_UNUSED_SVH

// Folds bits that are read on purpose by nobody into one dead net
// Use at most once per module
`define LSU_UNUSED(bits) \
  wire lsu_unused_bits = &{1'b0, bits}

`endif

/* lsu_mem.f */
+incdir+include
source/lsu_pkg.sv
source/lsu_req_stage.sv
source/lsu_bram.sv
source/lsu_load_align.sv
source/lsu_mem.sv
sim/lsu_mem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the lsu_mem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f lsu_mem.f \
  --top-module lsu_mem_tb \
  -o lsu_mem_sim

# Capture the output so it can be searched, the verdict comes from the search
sim_out="$(./obj_dir/lsu_mem_sim 2>&1)" || true
echo "$sim_out"

if grep -qx "Test passed" <<< "$sim_out"; then
  exit 0
fi
exit 1

/* sim/lsu_mem_tb.sv */
module lsu_mem_tb;
  import lsu_pkg::*;

  // Byte index width of the reference memory
  localparam int BYTE_AW = WORD_AW + 2;

  // One expected response and the cycle its request was issued in
  typedef struct packed {
    word_t       rdata;
    logic        err;
    logic [31:0] issue_cycle;
  } expect_t;

  logic     clk;
  logic     rst_n;
  logic     req_valid;
  lsu_req_t req;
  logic     rsp_valid;
  lsu_rsp_t rsp;

  // Reference memory, one entry per byte
  logic [7:0]  ref_mem [MEM_WORDS*4];
  expect_t     exp_q[$];
  expect_t     head;
  logic [15:0] lfsr_state = 16'd33312;
  logic [31:0] cycle = '0;
  int          mismatch_count;
  int          other_errors;

  lsu_mem lsu_mem_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  // 10 unit period
  always #5 clk = ~clk;

  // Cycle count, stable at every falling edge
  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  // Random word-aligned byte address, high bits left in to exercise wrap
  function automatic addr_t rand_word_addr();
    addr_t a;
    a = rand_bits(32);
    a[1:0] = 2'b00;
    return a;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      mismatch_count++;
    end
  endtask

  // Apply one request to the reference memory and work out its response
  task automatic apply_model(input lsu_req_t r, output word_t rdata, output logic err);
    logic [1:0] off;
    word_addr_t w;
    logic [7:0] b;
    logic [15:0] h;
    off   = r.addr[1:0];
    w     = r.addr[BYTE_AW-1:2];
    rdata = '0;
    // Halfwords on even bytes, words on multiples of four
    err = (r.size == SIZE_HALF && off[0]) || (r.size == SIZE_WORD && off != 2'b00);
    if (!err && r.store) begin
      case (r.size)
        SIZE_BYTE: begin
          ref_mem[{w, off}] = r.wdata[7:0];
        end
        SIZE_HALF: begin
          ref_mem[{w, off}]         = r.wdata[7:0];
          ref_mem[{w, off | 2'b01}] = r.wdata[15:8];
        end
        default: begin
          for (int k = 0; k < 4; k++) begin
            ref_mem[{w, k[1:0]}] = r.wdata[8*k +: 8];
          end
        end
      endcase
    end else if (!err) begin
      case (r.size)
        SIZE_BYTE: begin
          b     = ref_mem[{w, off}];
          rdata = r.is_unsigned ? {24'b0, b} : {{24{b[7]}}, b};
        end
        SIZE_HALF: begin
          h     = {ref_mem[{w, off | 2'b01}], ref_mem[{w, off}]};
          rdata = r.is_unsigned ? {16'b0, h} : {{16{h[15]}}, h};
        end
        default: begin
          rdata = {ref_mem[{w, 2'd3}], ref_mem[{w, 2'd2}],
                   ref_mem[{w, 2'd1}], ref_mem[{w, 2'd0}]};
        end
      endcase
    end
  endtask

  // Drive one request on the next falling edge, valid stays high
  task automatic issue_req(input logic store, input lsu_size_e size, input logic uns,
                           input addr_t addr, input word_t wdata);
    lsu_req_t r;
    expect_t  e;
    r.store       = store;
    r.size        = size;
    r.is_unsigned = uns;
    r.addr        = addr;
    r.wdata       = wdata;
    apply_model(r, e.rdata, e.err);
    @(negedge clk);
    req_valid     = 1'b1;
    req           = r;
    e.issue_cycle = cycle;
    exp_q.push_back(e);
  endtask

  // Stop issuing and wait for every outstanding response
  task automatic drain_responses(input int limit);
    int waited;
    waited = 0;
    @(negedge clk);
    req_valid = 1'b0;
    req       = '0;
    while (exp_q.size() != 0 && waited < limit) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout after %0d cycles with %0d responses still outstanding",
               waited, exp_q.size());
      other_errors++;
      exp_q.delete();
    end
  endtask

  // Nothing comes out while nothing goes in
  task automatic idle_after_reset();
    repeat (8) begin
      @(negedge clk);
      check_value("rsp_valid", {31'b0, rsp_valid}, 32'd0);
    end
  endtask

  // Latency is checked by the monitor for every response
  task automatic word_store_load();
    addr_t addrs[8];
    for (int i = 0; i < 8; i++) begin
      addrs[i] = rand_word_addr();
      issue_req(1'b1, SIZE_WORD, 1'b0, addrs[i], rand_bits(32));
    end
    for (int i = 0; i < 8; i++) begin
      issue_req(1'b0, SIZE_WORD, 1'b0, addrs[i], 32'd0);
    end
    drain_responses(20);
  endtask

  // Narrow stores land in their own lanes only
  // The word is read back after each one so untouched lanes are seen
  task automatic lane_merge();
    addr_t a;
    a = rand_word_addr();
    issue_req(1'b1, SIZE_WORD, 1'b0, a, 32'hA5A5_5A5A);
    issue_req(1'b1, SIZE_BYTE, 1'b0, a + 1, 32'hFFFF_FFC3);
    issue_req(1'b0, SIZE_WORD, 1'b0, a, 32'd0);
    // Upper half of wdata is ignored for a halfword
    issue_req(1'b1, SIZE_HALF, 1'b0, a + 2, 32'hDEAD_1E2D);
    issue_req(1'b0, SIZE_WORD, 1'b0, a, 32'd0);
    issue_req(1'b1, SIZE_BYTE, 1'b0, a, 32'h1234_5677);
    issue_req(1'b0, SIZE_WORD, 1'b0, a, 32'd0);
    drain_responses(20);
  endtask

  // Every lane with its top bit set in one pattern and clear in the other
  task automatic load_extension();
    word_t pats[2];
    addr_t a;
    pats[0] = 32'h80FF_7F01;
    pats[1] = 32'h7F00_80FE;
    for (int p = 0; p < 2; p++) begin
      a = rand_word_addr();
      issue_req(1'b1, SIZE_WORD, 1'b0, a, pats[p]);
      for (int off = 0; off < 4; off++) begin
        issue_req(1'b0, SIZE_BYTE, 1'b0, a + off, 32'd0);
        issue_req(1'b0, SIZE_BYTE, 1'b1, a + off, 32'd0);
      end
      for (int off = 0; off < 4; off += 2) begin
        issue_req(1'b0, SIZE_HALF, 1'b0, a + off, 32'd0);
        issue_req(1'b0, SIZE_HALF, 1'b1, a + off, 32'd0);
      end
    end
    drain_responses(20);
  endtask

  // Refused accesses return err and leave memory alone
  task automatic misaligned_access();
    addr_t a;
    a = rand_word_addr();
    issue_req(1'b1, SIZE_WORD, 1'b0, a, 32'h0BAD_F00D);
    issue_req(1'b0, SIZE_HALF, 1'b0, a + 1, 32'd0);
    issue_req(1'b0, SIZE_HALF, 1'b1, a + 3, 32'd0);
    issue_req(1'b0, SIZE_WORD, 1'b0, a + 2, 32'd0);
    issue_req(1'b1, SIZE_HALF, 1'b0, a + 1, 32'hFFFF_FFFF);
    issue_req(1'b1, SIZE_HALF, 1'b0, a + 3, 32'hFFFF_FFFF);
    issue_req(1'b1, SIZE_WORD, 1'b0, a + 1, 32'hFFFF_FFFF);
    issue_req(1'b1, SIZE_WORD, 1'b0, a + 2, 32'hFFFF_FFFF);
    issue_req(1'b1, SIZE_WORD, 1'b0, a + 3, 32'hFFFF_FFFF);
    // Still the first word
    issue_req(1'b0, SIZE_WORD, 1'b0, a, 32'd0);
    drain_responses(20);
  endtask

  // One request per cycle, loads right behind stores to the same word
  task automatic back_to_back_stream();
    addr_t a;
    addr_t b;
    a = rand_word_addr();
    b = rand_word_addr();
    issue_req(1'b1, SIZE_WORD, 1'b0, a, rand_bits(32));
    issue_req(1'b0, SIZE_WORD, 1'b0, a, 32'd0);
    issue_req(1'b1, SIZE_BYTE, 1'b0, a + 3, 32'h0000_0096);
    issue_req(1'b0, SIZE_BYTE, 1'b0, a + 3, 32'd0);
    issue_req(1'b1, SIZE_HALF, 1'b0, b + 2, rand_bits(32));
    issue_req(1'b0, SIZE_HALF, 1'b1, b + 2, 32'd0);
    issue_req(1'b0, SIZE_WORD, 1'b0, b + 1, 32'd0);
    issue_req(1'b1, SIZE_WORD, 1'b0, b, rand_bits(32));
    issue_req(1'b0, SIZE_WORD, 1'b0, b, 32'd0);
    issue_req(1'b0, SIZE_WORD, 1'b0, a, 32'd0);
    drain_responses(20);
  endtask

  // Response monitor
  // Samples on the falling edge, away from the DUT's register updates
  initial begin
    forever begin
      @(negedge clk);
      if (rst_n && rsp_valid) begin
        if (exp_q.size() == 0) begin
          $display("Response at %0t arrived with no request outstanding", $time);
          other_errors++;
        end else begin
          head = exp_q.pop_front();
          check_value("rsp.rdata", rsp.rdata, head.rdata);
          check_value("rsp.err", {31'b0, rsp.err}, {31'b0, head.err});
          // Exactly three cycles after issue
          check_value("rsp latency", cycle - head.issue_cycle, 32'd3);
        end
      end
    end
  end

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    req_valid      = 1'b0;
    req            = '0;
    mismatch_count = 0;
    other_errors   = 0;
    // DUT memory also starts out zero
    for (int i = 0; i < MEM_WORDS * 4; i++) begin
      ref_mem[i] = 8'h00;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    idle_after_reset();
    word_store_load();
    lane_merge();
    load_extension();
    misaligned_access();
    back_to_back_stream();

    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
    if (mismatch_count + other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* source/lsu_bram.sv */
module lsu_bram (
  input  logic              clk,
  input  logic              rst_n,
  input  lsu_pkg::mem_cmd_t cmd,
  output lsu_pkg::word_t    rd_data
);
  import lsu_pkg::*;

  // Inferred block RAM, one word per entry
  (* ramstyle = "block" *)
  (* ram_style = "block" *)
  word_t mem [MEM_WORDS];

  // Contents start out zero
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // Byte-strobed write
  // Lanes with a clear strobe keep their old byte
  always_ff @(posedge clk) begin
    if (cmd.wr_en) begin
      for (int i = 0; i < $bits(strb_t); i++) begin
        if (cmd.wr_strb[i]) begin
          mem[cmd.addr][i*8 +: 8] <= cmd.wr_data[i*8 +: 8];
        end
      end
    end
  end

  // Registered read with one cycle latency
  // Same-edge write is not seen, the old word comes out
  // Output holds its last value while no read is issued
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else if (cmd.rd_en) begin
      rd_data <= mem[cmd.addr];
    end
  end

  // Stage 1 never issues a write with no lane selected
  assert property (@(posedge clk) disable iff (!rst_n)
    cmd.wr_en |-> (cmd.wr_strb != '0));

endmodule

/* source/lsu_load_align.sv */
module lsu_load_align (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ctl_valid,
  input  lsu_pkg::lsu_ctl_t ctl,
  input  lsu_pkg::word_t    rd_data,
  output logic              rsp_valid,
  output lsu_pkg::lsu_rsp_t rsp
);
  import lsu_pkg::*;

  logic     ctl_valid_q;
  lsu_ctl_t ctl_q;
  word_t    shifted;
  word_t    load_data;
  lsu_rsp_t rsp_next;

  // One stage of delay to line control up with the RAM output
  always_ff @(posedge clk) begin
    ctl_q <= ctl;
    if (!rst_n) begin
      ctl_valid_q <= 1'b0;
    end else begin
      ctl_valid_q <= ctl_valid;
    end
  end

  // Bring the addressed lane down to bit 0
  assign shifted = rd_data >> {ctl_q.offset, 3'b000};

  // Extend by size and signedness
  always_comb begin
    case (ctl_q.size)
      SIZE_BYTE: begin
        if (ctl_q.is_unsigned) begin
          load_data = {24'b0, shifted[7:0]};
        end else begin
          load_data = {{24{shifted[7]}}, shifted[7:0]};
        end
      end
      SIZE_HALF: begin
        if (ctl_q.is_unsigned) begin
          load_data = {16'b0, shifted[15:0]};
        end else begin
          load_data = {{16{shifted[15]}}, shifted[15:0]};
        end
      end
      default: begin
        load_data = rd_data;
      end
    endcase
    // Stores and refused accesses return no data
    if (ctl_q.store || ctl_q.err) begin
      load_data = '0;
    end
  end

  always_comb begin
    rsp_next.rdata = load_data;
    rsp_next.err   = ctl_q.err;
  end

  // Response register, valid one cycle after the RAM data
  always_ff @(posedge clk) begin
    rsp <= rsp_next;
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= ctl_valid_q;
    end
  end

  // Every control strobe comes back as a response two cycles later
  assert property (@(posedge clk) disable iff (!rst_n)
    ($past(ctl_valid, 2) && $past(rst_n) && $past(rst_n, 2)) |-> rsp_valid);

  // And no response appears without one
  assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> $past(ctl_valid, 2));

endmodule

/* source/lsu_mem.sv */
module lsu_mem (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid,
  input  lsu_pkg::lsu_req_t req,
  output logic              rsp_valid,
  output lsu_pkg::lsu_rsp_t rsp
);
  import lsu_pkg::*;

  // Stage 1 to RAM
  mem_cmd_t cmd;

  // Stage 1 to stage 3, bypassing the RAM
  logic     ctl_valid;
  lsu_ctl_t ctl;

  // RAM to stage 3
  word_t    rd_data;

  // Decode, alignment check and lane placement
  lsu_req_stage lsu_req_stage_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req       (req),
    .cmd       (cmd),
    .ctl_valid (ctl_valid),
    .ctl       (ctl)
  );

  // Byte-strobed storage, one cycle read latency
  lsu_bram lsu_bram_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd     (cmd),
    .rd_data (rd_data)
  );

  // Lane extract, extension and response register
  lsu_load_align lsu_load_align_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctl_valid (ctl_valid),
    .ctl       (ctl),
    .rd_data   (rd_data),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

endmodule

/* source/lsu_pkg.sv */
package lsu_pkg;

  // Memory depth in 32-bit words
  localparam int MEM_WORDS = 1024;

  // Word index width into the RAM
  localparam int WORD_AW = $clog2(MEM_WORDS);

  // Byte address as seen by the core
  typedef logic [31:0] addr_t;

  // One data word
  typedef logic [31:0] word_t;

  // One strobe bit per byte lane
  typedef logic [3:0] strb_t;

  // Word index after the byte offset is dropped
  typedef logic [WORD_AW-1:0] word_addr_t;

  // Access size, encoding 2'b11 is reserved
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } lsu_size_e;

  // Request from the core, load when store is clear
  typedef struct packed {
    logic      store;
    lsu_size_e size;
    logic      is_unsigned;
    addr_t     addr;
    word_t     wdata;
  } lsu_req_t;

  // Control carried beside the RAM access
  typedef struct packed {
    logic      store;
    lsu_size_e size;
    logic      is_unsigned;
    logic [1:0] offset;
    logic      err;
  } lsu_ctl_t;

  // RAM command, one read or one write per cycle
  typedef struct packed {
    logic       rd_en;
    logic       wr_en;
    word_addr_t addr;
    word_t      wr_data;
    strb_t      wr_strb;
  } mem_cmd_t;

  // Response back to the core
  typedef struct packed {
    word_t rdata;
    logic  err;
  } lsu_rsp_t;

endpackage

/* source/lsu_req_stage.sv */
`include "lsu_unused.svh"

module lsu_req_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid,
  input  lsu_pkg::lsu_req_t req,
  output lsu_pkg::mem_cmd_t cmd,
  output logic              ctl_valid,
  output lsu_pkg::lsu_ctl_t ctl
);
  import lsu_pkg::*;

  logic [1:0] offset;
  logic       misaligned;
  strb_t      strb;
  word_t      lane_data;
  mem_cmd_t   cmd_next;
  lsu_ctl_t   ctl_next;

  // Byte position inside the addressed word
  assign offset = req.addr[1:0];

  // Size decode
  // Store data is replicated over all lanes and the strobes pick the live ones
  always_comb begin
    misaligned = 1'b0;
    strb       = '0;
    lane_data  = req.wdata;
    case (req.size)
      SIZE_BYTE: begin
        strb      = strb_t'(4'b0001 << offset);
        lane_data = {4{req.wdata[7:0]}};
      end
      SIZE_HALF: begin
        // Halfword must start on an even byte
        misaligned = offset[0];
        strb       = offset[1] ? 4'b1100 : 4'b0011;
        lane_data  = {2{req.wdata[15:0]}};
      end
      SIZE_WORD: begin
        misaligned = |offset;
        strb       = 4'b1111;
      end
      default: begin
        // Reserved size is refused like a misaligned access
        misaligned = 1'b1;
      end
    endcase
  end

  // Memory command for the next cycle
  // An erroring request never touches the RAM
  always_comb begin
    cmd_next.rd_en   = req_valid && !req.store && !misaligned;
    cmd_next.wr_en   = req_valid && req.store && !misaligned;
    cmd_next.addr    = req.addr[WORD_AW+1:2];
    cmd_next.wr_data = lane_data;
    cmd_next.wr_strb = req.store ? strb : '0;
  end

  // Control that rides along to the load aligner
  always_comb begin
    ctl_next.store       = req.store;
    ctl_next.size        = req.size;
    ctl_next.is_unsigned = req.is_unsigned;
    ctl_next.offset      = offset;
    ctl_next.err         = misaligned;
  end

  // Payload moves every cycle, only the enables and valid see reset
  always_ff @(posedge clk) begin
    cmd <= cmd_next;
    ctl <= ctl_next;
    if (!rst_n) begin
      cmd.rd_en <= 1'b0;
      cmd.wr_en <= 1'b0;
      ctl_valid <= 1'b0;
    end else begin
      ctl_valid <= req_valid;
    end
  end

  // A RAM write always belongs to a valid request that passed alignment
  assert property (@(posedge clk) disable iff (!rst_n)
    cmd.wr_en |-> (ctl_valid && ctl.store && !ctl.err));

  // The RAM port is shared, one access per cycle
  assert property (@(posedge clk) disable iff (!rst_n)
    !(cmd.rd_en && cmd.wr_en));

  // Address wraps above the RAM size
  // Upper store data is only live for word stores
  `LSU_UNUSED({req.addr[31:WORD_AW+2], req.wdata[31:16]});

endmodule
